// File: Makefile
VERILATOR ?= verilator
TOP       ?= periph_tb
FLIST     ?= periph_soc.f
OBJ_DIR   ?= obj_dir

SOURCES := $(shell grep -v '^+' $(FLIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a listed source or the file list changes
$(BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) --binary --timing --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# Pass only when the testbench prints its pass line
run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx "No errors"

clean:
	rm -rf $(OBJ_DIR)

// File: periph_soc.f
src/periph_pkg.sv
src/periph_router.sv
src/misc_regs.sv
src/led_frame_buffer.sv
src/led_matrix_scan.sv
src/periph_top.sv
verif/periph_assert.sv
verif/periph_tb.sv

// File: src/led_frame_buffer.sv
`timescale 1ns/1ns

module led_frame_buffer import periph_pkg::*; (
    input  logic                        clk_24mhz,
    input  logic                        rst_i,

    // Bus port
    input  logic                        stb_i,
    input  logic                        we_i,
    input  logic [REG_ADDR_WIDTH-1:0]   reg_adr_i,
    input  logic [WB_DATA_WIDTH-1:0]    dat_i,
    input  logic [WB_SEL_WIDTH-1:0]     sel_i,
    output logic                        ack_o,
    output logic [WB_DATA_WIDTH-1:0]    dat_o,

    // Scan port, byte index is bank * NUM_COLS + column
    input  logic [SCAN_INDEX_WIDTH-1:0] scan_index_i,
    output logic [ROW_WIDTH-1:0]        scan_byte_o
);

    logic [WB_DATA_WIDTH-1:0] mem [FB_WORDS];
    logic                     ack_q;
    logic                     first_cyc;
    logic                     in_range;
    logic [FB_ADDR_WIDTH-1:0] word_adr;
    logic [FB_ADDR_WIDTH-1:0] scan_word;
    logic [1:0]               scan_lane;
    logic [WB_DATA_WIDTH-1:0] rd_q;
    logic [ROW_WIDTH-1:0]     scan_q;

    assign first_cyc = stb_i & ~ack_q;
    assign in_range  = reg_adr_i < REG_ADDR_WIDTH'(FB_WORDS);
    assign word_adr  = reg_adr_i[FB_ADDR_WIDTH-1:0];
    assign scan_word = scan_index_i[SCAN_INDEX_WIDTH-1 -: FB_ADDR_WIDTH];
    assign scan_lane = scan_index_i[1:0];

    always_ff @(posedge clk_24mhz) begin
        if (rst_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= first_cyc;
        end
    end

    // Byte-lane writes and both read ports
    always_ff @(posedge clk_24mhz) begin
        if (first_cyc && we_i && in_range) begin
            for (int b = 0; b < WB_SEL_WIDTH; b++) begin
                if (sel_i[b]) begin
                    mem[word_adr][b*8 +: 8] <= dat_i[b*8 +: 8];
                end
            end
        end
        if (first_cyc) begin
            rd_q <= in_range ? mem[word_adr] : '0;
        end
        scan_q <= mem[scan_word][scan_lane*ROW_WIDTH +: ROW_WIDTH];
    end

    assign ack_o       = ack_q;
    assign dat_o       = rd_q;
    assign scan_byte_o = scan_q;

endmodule

// File: src/led_matrix_scan.sv
`timescale 1ns/1ns

module led_matrix_scan import periph_pkg::*; (
    input  logic                        clk_24mhz,
    input  logic                        rst_i,

    // Frame buffer read, byte arrives one cycle after the index
    output logic [SCAN_INDEX_WIDTH-1:0] scan_index_o,
    input  logic [ROW_WIDTH-1:0]        scan_byte_i,

    // Matrix drive
    output logic [NUM_BANKS-1:0]        row_bank_o,
    output logic [ROW_WIDTH-1:0]        row_data_o,
    output logic                        row_oe_n_o,
    output logic                        col_first_o,
    output logic                        col_advance_o,
    output logic                        col_rclk_o,
    output logic                        frame_complete_o
);

    logic [SLOT_CNT_WIDTH-1:0] cnt_q;
    logic [SLOT_CNT_WIDTH-1:0] next_cnt;
    logic [COL_WIDTH-1:0]      col_q;
    logic [BANK_WIDTH-1:0]     bank_q;
    logic                      slot_start;

    // col_q and bank_q name the slot that starts next, so the byte
    // is already fetched when that slot begins
    assign slot_start   = cnt_q == SLOT_CNT_WIDTH'(COL_PERIOD - 1);
    assign next_cnt     = slot_start ? '0 : cnt_q + 1'b1;
    assign scan_index_o = {bank_q, col_q};

    // ------------------------------------------------------------
    // Slot sequencer
    // ------------------------------------------------------------
    always_ff @(posedge clk_24mhz) begin
        if (rst_i) begin
            cnt_q            <= SLOT_CNT_WIDTH'(COL_PERIOD - 1);
            col_q            <= '0;
            bank_q           <= '0;
            row_bank_o       <= '0;
            row_oe_n_o       <= 1'b1;
            col_first_o      <= 1'b0;
            col_advance_o    <= 1'b0;
            col_rclk_o       <= 1'b0;
            frame_complete_o <= 1'b0;
        end else begin
            cnt_q         <= next_cnt;
            col_advance_o <= slot_start;
            col_first_o   <= slot_start && col_q == '0;
            col_rclk_o    <= next_cnt == SLOT_CNT_WIDTH'(1);
            row_oe_n_o    <= next_cnt < SLOT_CNT_WIDTH'(2);
            // Pointer has wrapped to bank 0 column 0 once the last slot runs
            frame_complete_o <= next_cnt == SLOT_CNT_WIDTH'(COL_PERIOD - 1)
                                && col_q == '0 && bank_q == '0;
            if (slot_start) begin
                row_bank_o <= NUM_BANKS'(1) << bank_q;
                if (col_q == COL_WIDTH'(NUM_COLS - 1)) begin
                    col_q  <= '0;
                    bank_q <= (bank_q == BANK_WIDTH'(NUM_BANKS - 1)) ? '0 : bank_q + 1'b1;
                end else begin
                    col_q <= col_q + 1'b1;
                end
            end
        end
    end

    // Row data latched on the rclk cycle and held for the slot
    always_ff @(posedge clk_24mhz) begin
        if (cnt_q == '0) begin
            row_data_o <= scan_byte_i;
        end
    end

endmodule

// File: src/misc_regs.sv
`timescale 1ns/1ns

module misc_regs import periph_pkg::*; (
    input  logic                      clk_24mhz,
    input  logic                      rst_i,

    // Register port
    input  logic                      stb_i,
    input  logic                      we_i,
    input  logic [REG_ADDR_WIDTH-1:0] reg_adr_i,
    input  logic [WB_DATA_WIDTH-1:0]  dat_i,
    output logic                      ack_o,
    output logic [WB_DATA_WIDTH-1:0]  dat_o,

    // Board side
    input  logic [NUM_BUTTONS-1:0]    buttons_i,
    output logic [NUM_LEDS-1:0]       stat_led_o,
    output logic                      irq_o
);

    misc_word_u             wr_word;
    misc_word_u             rd_word;
    logic                   ack_q;
    logic                   wr_en;
    logic [NUM_LEDS-1:0]    led_q;
    logic [NUM_BUTTONS-1:0] btn_meta;
    logic [NUM_BUTTONS-1:0] btn_sync;
    logic [NUM_BUTTONS-1:0] btn_prev;
    logic [NUM_BUTTONS-1:0] btn_rise;
    logic [NUM_BUTTONS-1:0] flag_clr;
    logic [NUM_BUTTONS-1:0] press_q;
    logic [NUM_BUTTONS-1:0] irq_en_q;

    assign wr_word = dat_i;
    assign wr_en   = stb_i & we_i & ~ack_q;

    // ------------------------------------------------------------
    // Button path
    // ------------------------------------------------------------
    assign btn_rise = btn_sync & ~btn_prev;
    // Write-one-to-clear on the flag field
    assign flag_clr = (wr_en && reg_adr_i == MISC_BUTTON) ? wr_word.btn.flag : '0;

    always_ff @(posedge clk_24mhz) begin
        if (rst_i) begin
            ack_q    <= 1'b0;
            led_q    <= '0;
            irq_en_q <= '0;
            btn_meta <= '0;
            btn_sync <= '0;
            btn_prev <= '0;
            press_q  <= '0;
        end else begin
            ack_q    <= stb_i & ~ack_q;
            btn_meta <= buttons_i;
            btn_sync <= btn_meta;
            btn_prev <= btn_sync;
            // A new press wins over a clear in the same cycle
            press_q  <= (press_q & ~flag_clr) | btn_rise;
            if (wr_en && reg_adr_i == MISC_LED) begin
                led_q <= wr_word.led.rgb;
            end
            if (wr_en && reg_adr_i == MISC_IRQ_EN) begin
                irq_en_q <= wr_word.btn.level;
            end
        end
    end

    // Read mux, unused offsets return zero
    always_comb begin
        rd_word = '0;
        case (reg_adr_i)
            MISC_LED: rd_word.led.rgb = led_q;
            MISC_BUTTON: begin
                rd_word.btn.level = btn_sync;
                rd_word.btn.flag  = press_q;
            end
            MISC_IRQ_EN: rd_word.btn.level = irq_en_q;
            default: ;
        endcase
    end

    assign ack_o      = ack_q;
    assign dat_o      = rd_word;
    assign stat_led_o = led_q;
    assign irq_o      = |(press_q & irq_en_q);

endmodule

// File: src/periph_pkg.sv
package periph_pkg;

    // ------------------------------------------------------------
    // Bus and address map
    // ------------------------------------------------------------
    localparam int WB_DATA_WIDTH     = 32;
    localparam int WB_SEL_WIDTH      = 4;
    localparam int PERIPH_ADDR_WIDTH = 12;
    localparam int SLAVE_SEL_WIDTH   = 4;
    localparam int REG_ADDR_WIDTH    = 8;

    localparam logic [SLAVE_SEL_WIDTH-1:0] SEL_MISC    = 4'd0;
    localparam logic [SLAVE_SEL_WIDTH-1:0] SEL_SERIAL  = 4'd1;
    localparam logic [SLAVE_SEL_WIDTH-1:0] SEL_DISPLAY = 4'd2;

    // Misc register offsets
    localparam logic [REG_ADDR_WIDTH-1:0] MISC_LED    = 8'd0;
    localparam logic [REG_ADDR_WIDTH-1:0] MISC_BUTTON = 8'd1;
    localparam logic [REG_ADDR_WIDTH-1:0] MISC_IRQ_EN = 8'd2;

    // ------------------------------------------------------------
    // Matrix geometry and scan timing
    // ------------------------------------------------------------
    localparam int NUM_BANKS        = 4;
    localparam int NUM_COLS         = 8;
    localparam int ROW_WIDTH        = 8;
    localparam int COL_PERIOD       = 16;
    localparam int BANK_WIDTH       = $clog2(NUM_BANKS);
    localparam int COL_WIDTH        = $clog2(NUM_COLS);
    localparam int SLOT_CNT_WIDTH   = $clog2(COL_PERIOD);
    localparam int SCAN_INDEX_WIDTH = BANK_WIDTH + COL_WIDTH;
    localparam int FB_WORDS         = NUM_BANKS * NUM_COLS / WB_SEL_WIDTH;
    localparam int FB_ADDR_WIDTH    = $clog2(FB_WORDS);

    localparam int NUM_LEDS     = 3;
    localparam int NUM_BUTTONS  = 2;
    localparam int BTN_FLAG_LSB = 8;

    // Misc data word, LED view at offset 0, button view at 1 and 2
    typedef union packed {
        struct packed {
            logic [WB_DATA_WIDTH-NUM_LEDS-1:0] rsvd;
            logic [NUM_LEDS-1:0]               rgb;
        } led;
        struct packed {
            logic [WB_DATA_WIDTH-BTN_FLAG_LSB-NUM_BUTTONS-1:0] rsvd_hi;
            logic [NUM_BUTTONS-1:0]                            flag;
            logic [BTN_FLAG_LSB-NUM_BUTTONS-1:0]               rsvd_lo;
            logic [NUM_BUTTONS-1:0]                            level;
        } btn;
    } misc_word_u;

endpackage

// File: src/periph_router.sv
`timescale 1ns/1ns

module periph_router import periph_pkg::*; (
    input  logic                       clk_24mhz,
    input  logic                       rst_i,

    // Request side
    input  logic                       wb_cyc_i,
    input  logic                       wb_stb_i,
    input  logic [SLAVE_SEL_WIDTH-1:0] wb_adr_i,
    output logic                       wb_ack_o,
    output logic                       wb_err_o,
    output logic [WB_DATA_WIDTH-1:0]   wb_dat_o,

    // Slave side
    output logic                       misc_stb_o,
    input  logic                       misc_ack_i,
    input  logic [WB_DATA_WIDTH-1:0]   misc_dat_i,
    output logic                       disp_stb_o,
    input  logic                       disp_ack_i,
    input  logic [WB_DATA_WIDTH-1:0]   disp_dat_i
);

    logic req;
    logic hit_misc;
    logic hit_disp;
    logic unmapped;
    logic err_q;

    assign req = wb_cyc_i & wb_stb_i;

    // ------------------------------------------------------------
    // Select decode
    // ------------------------------------------------------------
    always_comb begin
        hit_misc = 1'b0;
        hit_disp = 1'b0;
        case (wb_adr_i)
            SEL_MISC:    hit_misc = 1'b1;
            SEL_DISPLAY: hit_disp = 1'b1;
            // Serial slot stays in the map with nothing behind it
            SEL_SERIAL:  ;
            default:     ;
        endcase
    end

    assign unmapped   = ~(hit_misc | hit_disp);
    assign misc_stb_o = req & hit_misc;
    assign disp_stb_o = req & hit_disp;

    // Error answer for unmapped slots, same latency as a slave ack
    always_ff @(posedge clk_24mhz) begin
        if (rst_i) begin
            err_q <= 1'b0;
        end else begin
            err_q <= req & unmapped & ~err_q;
        end
    end

    // ------------------------------------------------------------
    // Response merge
    // ------------------------------------------------------------
    assign wb_ack_o = (hit_misc & misc_ack_i) | (hit_disp & disp_ack_i);
    assign wb_err_o = err_q;

    always_comb begin
        if (hit_misc) begin
            wb_dat_o = misc_dat_i;
        end else if (hit_disp) begin
            wb_dat_o = disp_dat_i;
        end else begin
            wb_dat_o = '0;
        end
    end

endmodule

// File: src/periph_top.sv
`timescale 1ns/1ns

module periph_top import periph_pkg::*; (
    input  logic                         clk_24mhz,
    input  logic                         rst_i,

    // Peripheral bus
    input  logic                         wb_cyc_i,
    input  logic                         wb_stb_i,
    input  logic                         wb_we_i,
    input  logic [PERIPH_ADDR_WIDTH-1:0] wb_adr_i,
    input  logic [WB_DATA_WIDTH-1:0]     wb_dat_i,
    input  logic [WB_SEL_WIDTH-1:0]      wb_sel_i,
    output logic                         wb_ack_o,
    output logic                         wb_err_o,
    output logic [WB_DATA_WIDTH-1:0]     wb_dat_o,

    // Status LEDs and buttons
    input  logic [NUM_BUTTONS-1:0]       buttons_i,
    output logic [NUM_LEDS-1:0]          stat_led_o,
    output logic                         irq_o,

    // LED matrix
    output logic [NUM_BANKS-1:0]         row_bank_o,
    output logic [ROW_WIDTH-1:0]         row_data_o,
    output logic                         row_oe_n_o,
    output logic                         col_first_o,
    output logic                         col_advance_o,
    output logic                         col_rclk_o,
    output logic                         frame_complete_o
);

    logic                        misc_stb;
    logic                        misc_ack;
    logic [WB_DATA_WIDTH-1:0]    misc_dat;
    logic                        disp_stb;
    logic                        disp_ack;
    logic [WB_DATA_WIDTH-1:0]    disp_dat;
    logic [SCAN_INDEX_WIDTH-1:0] scan_index;
    logic [ROW_WIDTH-1:0]        scan_byte;

    // ------------------------------------------------------------
    // Bus routing, select nibble sits on top of the register offset
    // ------------------------------------------------------------
    periph_router u_router (
        .clk_24mhz  (clk_24mhz),
        .rst_i      (rst_i),
        .wb_cyc_i   (wb_cyc_i),
        .wb_stb_i   (wb_stb_i),
        .wb_adr_i   (wb_adr_i[PERIPH_ADDR_WIDTH-1 -: SLAVE_SEL_WIDTH]),
        .wb_ack_o   (wb_ack_o),
        .wb_err_o   (wb_err_o),
        .wb_dat_o   (wb_dat_o),
        .misc_stb_o (misc_stb),
        .misc_ack_i (misc_ack),
        .misc_dat_i (misc_dat),
        .disp_stb_o (disp_stb),
        .disp_ack_i (disp_ack),
        .disp_dat_i (disp_dat)
    );

    misc_regs u_misc (
        .clk_24mhz  (clk_24mhz),
        .rst_i      (rst_i),
        .stb_i      (misc_stb),
        .we_i       (wb_we_i),
        .reg_adr_i  (wb_adr_i[REG_ADDR_WIDTH-1:0]),
        .dat_i      (wb_dat_i),
        .ack_o      (misc_ack),
        .dat_o      (misc_dat),
        .buttons_i  (buttons_i),
        .stat_led_o (stat_led_o),
        .irq_o      (irq_o)
    );

    // ------------------------------------------------------------
    // Display
    // ------------------------------------------------------------
    led_frame_buffer u_frame_buffer (
        .clk_24mhz    (clk_24mhz),
        .rst_i        (rst_i),
        .stb_i        (disp_stb),
        .we_i         (wb_we_i),
        .reg_adr_i    (wb_adr_i[REG_ADDR_WIDTH-1:0]),
        .dat_i        (wb_dat_i),
        .sel_i        (wb_sel_i),
        .ack_o        (disp_ack),
        .dat_o        (disp_dat),
        .scan_index_i (scan_index),
        .scan_byte_o  (scan_byte)
    );

    led_matrix_scan u_scan (
        .clk_24mhz        (clk_24mhz),
        .rst_i            (rst_i),
        .scan_index_o     (scan_index),
        .scan_byte_i      (scan_byte),
        .row_bank_o       (row_bank_o),
        .row_data_o       (row_data_o),
        .row_oe_n_o       (row_oe_n_o),
        .col_first_o      (col_first_o),
        .col_advance_o    (col_advance_o),
        .col_rclk_o       (col_rclk_o),
        .frame_complete_o (frame_complete_o)
    );

endmodule

// File: verif/periph_assert.sv
`timescale 1ns/1ns

module periph_assert (
    input logic clk_24mhz,
    input logic rst_i,
    input logic wb_cyc_i,
    input logic wb_stb_i,
    input logic wb_ack_o,
    input logic wb_err_o,
    input logic col_advance_o,
    input logic col_rclk_o,
    input logic row_oe_n_o
);

    // ------------------------------------------------------------
    // Bus response rules
    // ------------------------------------------------------------
    a_resp_excl: assert property (@(posedge clk_24mhz) disable iff (rst_i)
        !(wb_ack_o && wb_err_o))
        else $error("ack and err asserted in the same cycle");

    a_resp_in_req: assert property (@(posedge clk_24mhz) disable iff (rst_i)
        (wb_ack_o || wb_err_o) |-> (wb_cyc_i && wb_stb_i))
        else $error("bus response without an active strobe");

    // ------------------------------------------------------------
    // Scan timing
    // ------------------------------------------------------------
    a_rclk_follows: assert property (@(posedge clk_24mhz) disable iff (rst_i)
        col_rclk_o == $past(col_advance_o))
        else $error("col_rclk_o does not follow col_advance_o by one cycle");

    a_oe_off_rclk: assert property (@(posedge clk_24mhz) disable iff (rst_i)
        col_rclk_o |-> row_oe_n_o)
        else $error("row output enabled while latching row data");

endmodule

bind periph_top periph_assert u_assert (
    .clk_24mhz     (clk_24mhz),
    .rst_i         (rst_i),
    .wb_cyc_i      (wb_cyc_i),
    .wb_stb_i      (wb_stb_i),
    .wb_ack_o      (wb_ack_o),
    .wb_err_o      (wb_err_o),
    .col_advance_o (col_advance_o),
    .col_rclk_o    (col_rclk_o),
    .row_oe_n_o    (row_oe_n_o)
);

// File: verif/periph_tb.sv
`timescale 1ns/1ns

module periph_tb import periph_pkg::*; ();

    localparam int FRAME_CYCLES    = NUM_BANKS * NUM_COLS * COL_PERIOD;
    localparam int WATCHDOG_CYCLES = 5 * FRAME_CYCLES + 2000;
    localparam int WORDS_PER_BANK  = NUM_COLS / WB_SEL_WIDTH;

    logic                         clk_24mhz;
    logic                         rst_i;
    logic                         wb_cyc_i;
    logic                         wb_stb_i;
    logic                         wb_we_i;
    logic [PERIPH_ADDR_WIDTH-1:0] wb_adr_i;
    logic [WB_DATA_WIDTH-1:0]     wb_dat_i;
    logic [WB_SEL_WIDTH-1:0]      wb_sel_i;
    logic                         wb_ack_o;
    logic                         wb_err_o;
    logic [WB_DATA_WIDTH-1:0]     wb_dat_o;
    logic [NUM_BUTTONS-1:0]       buttons_i;
    logic [NUM_LEDS-1:0]          stat_led_o;
    logic                         irq_o;
    logic [NUM_BANKS-1:0]         row_bank_o;
    logic [ROW_WIDTH-1:0]         row_data_o;
    logic                         row_oe_n_o;
    logic                         col_first_o;
    logic                         col_advance_o;
    logic                         col_rclk_o;
    logic                         frame_complete_o;

    logic [31:0] lcg_state;
    logic [31:0] fb_model [FB_WORDS];

    periph_top DUT (.*);

    initial clk_24mhz = 1'b0;
    always #50 clk_24mhz = ~clk_24mhz;

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------
    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s = %h, expected %h",
                     $time, name, actual, expected);
            fail_run("Stopping at the first mismatch");
        end
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [PERIPH_ADDR_WIDTH-1:0] reg_addr(input logic [3:0] sel_code,
                                                              input logic [7:0] offset);
        return {sel_code, offset};
    endfunction

    // Byte lane rule, word holds half a bank row
    function automatic logic [7:0] expected_byte(input int bank, input int col);
        int word;
        int lane;
        word = bank * WORDS_PER_BANK + col / WB_SEL_WIDTH;
        lane = col % WB_SEL_WIDTH;
        return fb_model[word][lane*8 +: 8];
    endfunction

    // Inputs change and outputs are sampled 5 ns after the edge
    task automatic next_cycle();
        @(posedge clk_24mhz);
        #5;
    endtask

    task automatic bus_access(input logic we, input logic [PERIPH_ADDR_WIDTH-1:0] adr,
                              input logic [31:0] wdata, input logic [3:0] sel,
                              output logic [31:0] rdata, output logic got_err);
        int wait_cycles;
        wait_cycles = 0;
        next_cycle();
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = wdata;
        wb_sel_i = sel;
        next_cycle();
        while (!wb_ack_o && !wb_err_o && wait_cycles < 8) begin
            wait_cycles++;
            next_cycle();
        end
        if (!wb_ack_o && !wb_err_o) begin
            fail_run("Bus access got neither ack nor err");
        end
        rdata   = wb_dat_o;
        got_err = wb_err_o;
        // Hold the strobe through the response edge
        next_cycle();
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    task automatic bus_write(input logic [PERIPH_ADDR_WIDTH-1:0] adr,
                             input logic [31:0] wdata, input logic [3:0] sel);
        logic [31:0] unused;
        logic        got_err;
        bus_access(1'b1, adr, wdata, sel, unused, got_err);
        check_value("wb_err_o on write", got_err, 0);
    endtask

    task automatic bus_read(input logic [PERIPH_ADDR_WIDTH-1:0] adr,
                            output logic [31:0] rdata);
        logic got_err;
        bus_access(1'b0, adr, 32'h0, 4'hf, rdata, got_err);
        check_value("wb_err_o on read", got_err, 0);
    endtask

    // ------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------
    task automatic test_leds();
        logic [31:0] data;
        logic [31:0] rd;
        check_value("stat_led_o after reset", stat_led_o, 0);
        for (int i = 0; i < 6; i++) begin
            data = lcg_next();
            bus_write(reg_addr(SEL_MISC, MISC_LED), data, 4'hf);
            check_value("stat_led_o", stat_led_o, data[2:0]);
            bus_read(reg_addr(SEL_MISC, MISC_LED), rd);
            check_value("LED register", rd, {29'h0, data[2:0]});
        end
    endtask

    task automatic test_unmapped();
        logic [31:0] data;
        logic [31:0] rd;
        logic        got_err;
        data = lcg_next();
        bus_write(reg_addr(SEL_DISPLAY, 8'd3), data, 4'hf);
        for (int s = 0; s < 16; s++) begin
            if (s != SEL_MISC && s != SEL_DISPLAY) begin
                bus_access(1'b1, reg_addr(4'(s), 8'd3), lcg_next(), 4'hf, rd, got_err);
                check_value("wb_err_o on unmapped write", got_err, 1);
                bus_access(1'b0, reg_addr(4'(s), 8'd3), 32'h0, 4'hf, rd, got_err);
                check_value("wb_err_o on unmapped read", got_err, 1);
            end
        end
        bus_read(reg_addr(SEL_DISPLAY, 8'd3), rd);
        check_value("display word 3 after unmapped writes", rd, data);
    endtask

    task automatic test_byte_lanes();
        logic [31:0] data;
        logic [31:0] rd;
        logic [3:0]  sel;
        for (int w = 0; w < FB_WORDS; w++) begin
            fb_model[w] = lcg_next();
            bus_write(reg_addr(SEL_DISPLAY, 8'(w)), fb_model[w], 4'hf);
        end
        for (int w = 0; w < FB_WORDS; w++) begin
            bus_read(reg_addr(SEL_DISPLAY, 8'(w)), rd);
            check_value("frame buffer full word", rd, fb_model[w]);
        end
        for (int w = 0; w < FB_WORDS; w++) begin
            data = lcg_next();
            sel  = 4'(lcg_next() >> 28);
            bus_write(reg_addr(SEL_DISPLAY, 8'(w)), data, sel);
            for (int b = 0; b < WB_SEL_WIDTH; b++) begin
                if (sel[b]) fb_model[w][b*8 +: 8] = data[b*8 +: 8];
            end
            bus_read(reg_addr(SEL_DISPLAY, 8'(w)), rd);
            check_value("frame buffer partial word", rd, fb_model[w]);
        end
    endtask

    task automatic test_scan();
        int wait_cycles;
        int slot;
        int col;
        int rclk_count;
        int frame_count;
        for (int w = 0; w < FB_WORDS; w++) begin
            fb_model[w] = lcg_next();
            bus_write(reg_addr(SEL_DISPLAY, 8'(w)), fb_model[w], 4'hf);
        end
        wait_cycles = 0;
        next_cycle();
        while (!(col_first_o && row_bank_o == 4'b0001) && wait_cycles < 2 * FRAME_CYCLES) begin
            wait_cycles++;
            next_cycle();
        end
        if (!(col_first_o && row_bank_o == 4'b0001)) begin
            fail_run("Scanner never started a frame at bank 0");
        end
        slot        = -1;
        col         = 0;
        rclk_count  = 0;
        frame_count = 0;
        for (int i = 0; i < FRAME_CYCLES; i++) begin
            if (i > 0) next_cycle();
            // Outputs stay dark in the first two cycles of each slot
            check_value("row_oe_n_o", row_oe_n_o, (i % COL_PERIOD) < 2);
            if (col_advance_o) begin
                slot++;
                col = col_first_o ? 0 : col + 1;
            end
            if (col_rclk_o) begin
                rclk_count++;
                check_value("row_bank_o", row_bank_o, 1 << (slot / NUM_COLS));
                check_value("row_data_o", row_data_o, expected_byte(slot / NUM_COLS, col));
            end
            if (frame_complete_o) begin
                frame_count++;
                check_value("columns before frame_complete_o", rclk_count,
                            NUM_BANKS * NUM_COLS);
            end
        end
        check_value("frame_complete_o pulses", frame_count, 1);
    endtask

    // Reads until the button word settles, the synchronizer adds a few cycles
    task automatic poll_button_reg(input logic [31:0] expected, input string what);
        logic [31:0] rd;
        int          tries;
        tries = 0;
        bus_read(reg_addr(SEL_MISC, MISC_BUTTON), rd);
        while (rd != expected && tries < 8) begin
            tries++;
            bus_read(reg_addr(SEL_MISC, MISC_BUTTON), rd);
        end
        check_value(what, rd, expected);
    endtask

    task automatic test_buttons();
        logic [31:0] rd;
        check_value("irq_o before press", irq_o, 0);
        next_cycle();
        buttons_i = 2'b01;
        poll_button_reg(32'h0000_0101, "button 0 level and flag");
        check_value("irq_o while masked", irq_o, 0);
        bus_write(reg_addr(SEL_MISC, MISC_IRQ_EN), 32'h1, 4'hf);
        bus_read(reg_addr(SEL_MISC, MISC_IRQ_EN), rd);
        check_value("interrupt enable register", rd, 32'h1);
        check_value("irq_o after enable", irq_o, 1);
        bus_write(reg_addr(SEL_MISC, MISC_BUTTON), 32'h0000_0100, 4'hf);
        check_value("irq_o after flag clear", irq_o, 0);
        poll_button_reg(32'h0000_0001, "button word after flag clear");
        next_cycle();
        buttons_i = 2'b11;
        poll_button_reg(32'h0000_0203, "button 1 level and flag");
        check_value("irq_o with button 1 masked", irq_o, 0);
    endtask

    // ------------------------------------------------------------
    // Main sequence and watchdog
    // ------------------------------------------------------------
    initial begin
        lcg_state   = 32'h621f_9aca;
        rst_i       = 1'b1;
        wb_cyc_i    = 1'b0;
        wb_stb_i    = 1'b0;
        wb_we_i     = 1'b0;
        wb_adr_i    = '0;
        wb_dat_i    = '0;
        wb_sel_i    = '0;
        buttons_i   = '0;
        repeat (16) @(posedge clk_24mhz);
        #5;
        rst_i = 1'b0;

        test_leds();
        test_unmapped();
        test_byte_lanes();
        test_scan();
        test_buttons();

        $display("No errors");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_24mhz);
        fail_run("The run timed out before all tests finished");
    end

endmodule
